//--- dbg_cmd_exec.sv
/*
 Applies captured debug words one cycle after word_valid.
 Select 0 decodes a command on the control registers and builds a reply;
 select 1 forwards the raw word to the mailbox with a one-cycle strobe.
 Addresses at or beyond DBG_REG_COUNT change nothing and reply with an error tag.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_cmd_exec (
	input  wire                           clk48m,
	input  wire                           jrstn,
	input  wire                           word_valid,
	input  wire dbg_pkg::dbg_word_u       word,
	input  wire                           word_sel,
	output logic [`DBG_REG_COUNT*24-1:0]  ctrl_regs, // reg i at [i*24 +: 24]
	output logic [31:0]                   reply,
	output logic [31:0]                   mbox_word,
	output logic                          mbox_strobe
);

	import dbg_pkg::*;

	localparam int NREG  = `DBG_REG_COUNT;
	localparam int REG_W = 24;

	dbg_cmd_t         cmd;
	logic             addr_ok;
	logic [REG_W-1:0] rd_data;

	assign cmd = word.cmd;

	// addr is 6 bits, count may be 64, so compare one bit wider
	assign addr_ok = ({1'b0, cmd.addr} < 7'(NREG));

	// read mux over the register bank
	always_comb begin
		rd_data = '0;
		for (int i = 0; i < NREG; i++) begin
			if (cmd.addr == 6'(i)) begin
				rd_data = ctrl_regs[i*REG_W +: REG_W];
			end
		end
	end

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			ctrl_regs   <= '0;
			reply       <= '0;
			mbox_word   <= '0;
			mbox_strobe <= 1'b0;
		end else begin
			mbox_strobe <= 1'b0;
			if (word_valid) begin
				if (word_sel) begin
					// mailbox path, reply untouched
					mbox_word   <= word.raw;
					mbox_strobe <= 1'b1;
				end else if (!addr_ok) begin
					reply <= {DBG_ERR_TAG, {REG_W{1'b0}}};
				end else begin
					case (cmd.op)
						OP_WRITE: begin
							for (int i = 0; i < NREG; i++) begin
								if (cmd.addr == 6'(i)) begin
									ctrl_regs[i*REG_W +: REG_W] <= cmd.data;
								end
							end
							reply <= {cmd.op, cmd.addr, cmd.data};
						end
						OP_READ: begin
							reply <= {cmd.op, cmd.addr, rd_data};
						end
						OP_CLEAR: begin
							ctrl_regs <= '0; // whole bank, addr only echoed
							reply     <= {cmd.op, cmd.addr, {REG_W{1'b0}}};
						end
						default: begin // nop
							reply <= {cmd.op, cmd.addr, {REG_W{1'b0}}};
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- dbg_pkg.sv
/*
 Types shared by the debug-register path.
 A captured word is read as a command for user register 1 (IR 0x32)
 and as a raw mailbox word for user register 2 (IR 0x38).
*/
`default_nettype none

`include "dbg_settings.svh"

package dbg_pkg;

	// command opcodes, top two bits of the word
	typedef enum logic [1:0] {
		OP_NOP   = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2,
		OP_CLEAR = 2'd3
	} dbg_op_t;

	// 32-bit command layout, msb first
	typedef struct packed {
		dbg_op_t     op;   // 31..30
		logic [5:0]  addr; // 29..24
		logic [23:0] data; // 23..0
	} dbg_cmd_t;

	// one captured word, two views of it
	typedef union packed {
		logic [`DBG_WORD_W-1:0] raw;
		dbg_cmd_t               cmd;
	} dbg_word_u;

	// reply top byte when addr is out of range
	localparam logic [7:0] DBG_ERR_TAG = 8'hEE;

endpackage

`default_nettype wire

//--- dbg_settings.svh
/*
 Build settings for the JTAG debug-register path.
 DBG_SYNC_STAGES must be 3 or more; each jtck level has to be held for
 at least DBG_SYNC_STAGES+2 clk48m cycles.
 The command layout assumes DBG_WORD_W is 32; DBG_REG_COUNT is at most 64.
*/
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

// depth of the jtck/jtdi sampling chain in clk48m
`define DBG_SYNC_STAGES 4

// data register width, fixed by the command layout
`define DBG_WORD_W 32

// number of 24-bit control registers
`define DBG_REG_COUNT 4

`endif

//--- dr_shifter.sv
/*
 JTAG data register in the clk48m domain, LSB shifted in first.
 Acts one cycle after each tck_rise. The last captured word and select
 hold until the next update; word_valid marks a fresh capture.
 No TDO path is provided.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module dr_shifter (
	input  wire                    clk48m,
	input  wire                    jrstn,
	input  wire                    tck_rise,
	input  wire                    s_tdi,
	input  wire                    s_shift,
	input  wire                    s_update,
	input  wire                    s_ce1,
	input  wire                    s_ce2,
	output logic                   word_valid,
	output dbg_pkg::dbg_word_u     word,
	output logic                   word_sel
);

	localparam int W = `DBG_WORD_W;

	logic [W-1:0] sh_reg;    // shift chain
	logic         old_shift; // shift level at the previous edge
	logic         pend_sel;  // 0 = IR 0x32, 1 = IR 0x38

	// shift state machine; jshift is high on the edge that enters
	// shift-dr, so the bit is taken one edge later
	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			sh_reg     <= '0;
			old_shift  <= 1'b0;
			pend_sel   <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			if (tck_rise) begin
				if (old_shift) begin
					sh_reg <= {s_tdi, sh_reg[W-1:1]};
				end
				if (s_ce1 || s_ce2) begin
					pend_sel <= s_ce2;
				end
				if (s_update) begin
					word_valid <= 1'b1;
				end
				old_shift <= s_shift;
			end
		end
	end

	// captured word, only qualified by word_valid
	always_ff @(posedge clk48m) begin
		if (tck_rise && s_update) begin
			word.raw <= sh_reg;
			word_sel <= pend_sel;
		end
	end

endmodule

`default_nettype wire

//--- jtag_dbg_top.sv
/*
 Debug-register path top level: sampler, DR shifter, command executor.
 The JTAG primitive outputs arrive as plain levels; clk48m must run
 much faster than jtck. There is no TDO and no back-pressure.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module jtag_dbg_top (
	input  wire                           clk48m,
	input  wire                           jrstn,
	input  wire                           jtck,
	input  wire                           jtdi,
	input  wire                           jshift,
	input  wire                           jupdate,
	input  wire                           jce1,
	input  wire                           jce2,
	output logic [`DBG_REG_COUNT*24-1:0]  ctrl_regs,
	output logic [31:0]                   reply,
	output logic [31:0]                   mbox_word,
	output logic                          mbox_strobe
);

	import dbg_pkg::*;

	// sampler to shifter
	logic tck_rise;
	logic s_tdi;
	logic s_shift;
	logic s_update;
	logic s_ce1;
	logic s_ce2;

	// shifter to executor
	logic      word_valid;
	dbg_word_u word;
	logic      word_sel;

	tck_sampler u_sampler (
		.clk48m   (clk48m),
		.jrstn    (jrstn),
		.jtck     (jtck),
		.jtdi     (jtdi),
		.jshift   (jshift),
		.jupdate  (jupdate),
		.jce1     (jce1),
		.jce2     (jce2),
		.tck_rise (tck_rise),
		.s_tdi    (s_tdi),
		.s_shift  (s_shift),
		.s_update (s_update),
		.s_ce1    (s_ce1),
		.s_ce2    (s_ce2)
	);

	dr_shifter u_shifter (
		.clk48m     (clk48m),
		.jrstn      (jrstn),
		.tck_rise   (tck_rise),
		.s_tdi      (s_tdi),
		.s_shift    (s_shift),
		.s_update   (s_update),
		.s_ce1      (s_ce1),
		.s_ce2      (s_ce2),
		.word_valid (word_valid),
		.word       (word),
		.word_sel   (word_sel) // 0 for IR 0x32, 1 for IR 0x38
	);

	dbg_cmd_exec u_exec (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.word_valid  (word_valid),
		.word        (word),
		.word_sel    (word_sel),
		.ctrl_regs   (ctrl_regs),
		.reply       (reply),
		.mbox_word   (mbox_word),
		.mbox_strobe (mbox_strobe)
	);

endmodule

`default_nettype wire

//--- project.f
+incdir+.
dbg_pkg.sv
tck_sampler.sv
dr_shifter.sv
dbg_cmd_exec.sv
jtag_dbg_top.sv
tb_jtag_dbg.sv

//--- run_sim.sh
#!/bin/sh
# Builds the JTAG debug-register testbench with Verilator and runs it.
# Pass or fail is decided from the simulation output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_jtag_dbg -o sim_jtag_dbg

# the simulator exits non-zero on a failed check, the output is searched below
out=$(./obj_dir/sim_jtag_dbg 2>&1) || true
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
	exit 0
else
	echo "run_sim.sh: pass message not found in simulation output"
	exit 1
fi

//--- tb_jtag_dbg.sv
/*
 Testbench for the JTAG debug-register path.
 Drives the JTAG primitive outputs directly, each jtck level held for
 DBG_SYNC_STAGES+4 clk48m cycles, and checks the top-level ports after
 every stimulus table entry. TDO is not modelled.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module tb_jtag_dbg;

	localparam int NREG     = `DBG_REG_COUNT;
	localparam int RW       = NREG * 24;
	localparam int CHK_W    = (RW > 32) ? RW : 32;
	localparam int HOLD     = `DBG_SYNC_STAGES + 4;
	localparam int SETTLE   = 6;
	localparam int WORD_CYC = 35 * 2 * HOLD + SETTLE; // longest word is 35 jtck edges
	localparam int MAX_ENT  = 2 * NREG + 16;

	// opcodes of the command layout
	localparam logic [1:0] OPC_NOP   = 2'd0;
	localparam logic [1:0] OPC_WRITE = 2'd1;
	localparam logic [1:0] OPC_READ  = 2'd2;
	localparam logic [1:0] OPC_CLEAR = 2'd3;

	logic          clk48m = 1'b0;
	logic          jrstn;
	logic          jtck;
	logic          jtdi;
	logic          jshift;
	logic          jupdate;
	logic          jce1;
	logic          jce2;
	logic [RW-1:0] ctrl_regs;
	logic [31:0]   reply;
	logic [31:0]   mbox_word;
	logic          mbox_strobe;

	// stimulus table with expected values
	logic          t_sel   [MAX_ENT];
	logic [31:0]   t_word  [MAX_ENT];
	logic          t_shift [MAX_ENT];
	logic          t_upd   [MAX_ENT];
	logic [31:0]   t_reply [MAX_ENT];
	logic [RW-1:0] t_regs  [MAX_ENT];
	logic [31:0]   t_mbox  [MAX_ENT];
	int            t_pulse [MAX_ENT];
	int            n_ent;
	logic          table_ready = 1'b0;

	// expected DUT state while the table is built
	logic [RW-1:0] m_regs;
	logic [31:0]   m_reply;
	logic [31:0]   m_mbox;
	logic [31:0]   last_shifted;

	integer        seed;
	int            pulse_cnt = 0;
	int            cur_ent;

	jtag_dbg_top UUT (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.jtck        (jtck),
		.jtdi        (jtdi),
		.jshift      (jshift),
		.jupdate     (jupdate),
		.jce1        (jce1),
		.jce2        (jce2),
		.ctrl_regs   (ctrl_regs),
		.reply       (reply),
		.mbox_word   (mbox_word),
		.mbox_strobe (mbox_strobe)
	);

	always #5 clk48m = ~clk48m;

	// every cycle with mbox_strobe high counts as one pulse
	always @(posedge clk48m) begin
		if (jrstn && mbox_strobe) begin
			pulse_cnt <= pulse_cnt + 1;
		end
	end

	task automatic check_eq(input string name, input logic [CHK_W-1:0] got,
			input logic [CHK_W-1:0] exp);
		if (got !== exp) begin
			$display("[FAIL] entry %0d %s = 0x%h, expected 0x%h", cur_ent, name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// appends one entry and moves the expected state forward
	task automatic add_entry(input logic sel, input logic [31:0] w, input logic do_shift,
			input logic do_upd);
		logic [1:0]  op;
		int          ad;
		logic [23:0] dt;
		if (n_ent >= MAX_ENT) begin
			$display("the stimulus table is too small for the entries it should hold");
			$display("SIMULATION FAILED");
			$fatal(1, "table overflow");
		end else begin
			if (do_shift) begin
				last_shifted = w;
			end
			op = last_shifted[31:30];
			ad = int'(last_shifted[29:24]);
			dt = last_shifted[23:0];
			if (do_upd && sel) begin
				m_mbox = last_shifted; // reply and registers hold
			end else if (do_upd && ad >= NREG) begin
				m_reply = {8'hEE, 24'h000000};
			end else if (do_upd) begin
				case (op)
					OPC_WRITE: begin
						m_regs[ad*24 +: 24] = dt;
						m_reply = {op, 6'(ad), dt};
					end
					OPC_READ:  m_reply = {op, 6'(ad), m_regs[ad*24 +: 24]};
					OPC_CLEAR: begin
						m_regs  = '0;
						m_reply = {op, 6'(ad), 24'h000000};
					end
					default:   m_reply = {op, 6'(ad), 24'h000000};
				endcase
			end
			t_sel[n_ent]   = sel;
			t_word[n_ent]  = w;
			t_shift[n_ent] = do_shift;
			t_upd[n_ent]   = do_upd;
			t_reply[n_ent] = m_reply;
			t_regs[n_ent]  = m_regs;
			t_mbox[n_ent]  = m_mbox;
			t_pulse[n_ent] = (do_upd && sel) ? 1 : 0;
			n_ent = n_ent + 1;
		end
	endtask

	task automatic build_table();
		logic [31:0] w;
		logic [23:0] dt;
		m_regs       = '0;
		m_reply      = '0;
		m_mbox       = '0;
		last_shifted = '0;
		n_ent        = 0;
		for (int a = 0; a < NREG; a++) begin
			dt = 24'(32'h00a5_1000 + 32'(a) * 32'h0001_0203);
			add_entry(1'b0, {OPC_WRITE, 6'(a), dt}, 1'b1, 1'b1);
		end
		// data field of a read is ignored, so fill it with ones
		for (int a = 0; a < NREG; a++) begin
			add_entry(1'b0, {OPC_READ, 6'(a), 24'hffffff}, 1'b1, 1'b1);
		end
		if (NREG < 64) begin
			add_entry(1'b0, {OPC_WRITE, 6'(NREG), 24'h123456}, 1'b1, 1'b1);
		end
		// the nop reply differs from any error reply the mailbox words could cause
		add_entry(1'b0, {OPC_NOP, 6'd1, 24'habcdef}, 1'b1, 1'b1);
		for (int k = 0; k < 3; k++) begin
			w = $random(seed);
			add_entry(1'b1, w, 1'b1, 1'b1); // mailbox
		end
		add_entry(1'b0, {OPC_READ, 6'd63, 24'h000000}, 1'b1, 1'b1);
		// two words shifted without update, then a bare update edge
		add_entry(1'b0, {OPC_WRITE, 6'd0, 24'h111111}, 1'b1, 1'b0);
		add_entry(1'b0, {OPC_WRITE, 6'd1, 24'h222222}, 1'b1, 1'b0);
		add_entry(1'b0, 32'h0000_0000, 1'b0, 1'b1);
		add_entry(1'b0, {OPC_CLEAR, 6'd2, 24'h777777}, 1'b1, 1'b1);
		add_entry(1'b0, {OPC_READ, 6'd0, 24'h000000}, 1'b1, 1'b1);
		w = $random(seed);
		add_entry(1'b1, w, 1'b1, 1'b1);
	endtask

	// one full jtck period with the levels set while jtck is low
	task automatic tck_cycle(input logic tdi, input logic shift, input logic upd,
			input logic ce1, input logic ce2);
		jtdi    = tdi;
		jshift  = shift;
		jupdate = upd;
		jce1    = ce1;
		jce2    = ce2;
		repeat (HOLD) @(negedge clk48m);
		jtck = 1'b1;
		repeat (HOLD) @(negedge clk48m);
		jtck = 1'b0;
	endtask

	// select, shift and update phases of one data-register access
	task automatic shift_word(input logic sel, input logic [31:0] w, input logic do_shift,
			input logic do_upd);
		tck_cycle(1'b0, 1'b0, 1'b0, !sel, sel);
		if (do_shift) begin
			// a bit is taken on the edge after a shift-high edge, so jshift
			// rises one edge early and the last bit goes in with it low
			tck_cycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
			for (int i = 0; i < 32; i++) begin
				tck_cycle(w[i], (i < 31), 1'b0, 1'b0, 1'b0);
			end
		end
		if (do_upd) begin
			tck_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		end
		jtdi    = 1'b0;
		jshift  = 1'b0;
		jupdate = 1'b0;
		jce1    = 1'b0;
		jce2    = 1'b0;
	endtask

	initial begin
		int cnt0;
		jrstn   = 1'b0;
		jtck    = 1'b0;
		jtdi    = 1'b0;
		jshift  = 1'b0;
		jupdate = 1'b0;
		jce1    = 1'b0;
		jce2    = 1'b0;
		cur_ent = -1; // -1 marks the post-reset checks
		seed    = 32'h5881;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(negedge clk48m);
		jrstn = 1'b1;
		repeat (SETTLE) @(negedge clk48m);
		check_eq("ctrl_regs", CHK_W'(ctrl_regs), CHK_W'(0));
		check_eq("reply", CHK_W'(reply), CHK_W'(0));
		check_eq("mbox_word", CHK_W'(mbox_word), CHK_W'(0));
		check_eq("mbox_strobe pulses", CHK_W'(pulse_cnt), CHK_W'(0));
		for (int e = 0; e < n_ent; e++) begin
			cur_ent = e;
			cnt0    = pulse_cnt;
			shift_word(t_sel[e], t_word[e], t_shift[e], t_upd[e]);
			repeat (SETTLE) @(negedge clk48m);
			check_eq("reply", CHK_W'(reply), CHK_W'(t_reply[e]));
			check_eq("ctrl_regs", CHK_W'(ctrl_regs), CHK_W'(t_regs[e]));
			check_eq("mbox_word", CHK_W'(mbox_word), CHK_W'(t_mbox[e]));
			check_eq("mbox_strobe pulses", CHK_W'(pulse_cnt - cnt0), CHK_W'(t_pulse[e]));
		end
		$display("SIMULATION PASSED");
		$finish;
	end

	// watchdog allows twice the worst-case length of the table
	initial begin
		int limit;
		wait (table_ready === 1'b1);
		limit = (n_ent + 2) * WORD_CYC * 2;
		repeat (limit) @(posedge clk48m);
		$display("timeout, the run did not finish within %0d clk48m cycles", limit);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- tck_sampler.sv
/*
 Samples the JTAG primitive outputs into clk48m.
 All six inputs go through DBG_SYNC_STAGES flops; the tck edge is taken
 at the oldest end of the chain, so data levels line up with tck_rise.
 jtck must stay in each level for at least DBG_SYNC_STAGES+2 cycles.
*/
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module tck_sampler (
	input  wire  clk48m,
	input  wire  jrstn,
	input  wire  jtck,
	input  wire  jtdi,
	input  wire  jshift,
	input  wire  jupdate,
	input  wire  jce1,
	input  wire  jce2,
	output logic tck_rise,
	output logic s_tdi,
	output logic s_shift,
	output logic s_update,
	output logic s_ce1,
	output logic s_ce2
);

	localparam int N = `DBG_SYNC_STAGES;

	// bit positions inside one sample
	localparam int B_TCK    = 0;
	localparam int B_TDI    = 1;
	localparam int B_SHIFT  = 2;
	localparam int B_UPDATE = 3;
	localparam int B_CE1    = 4;
	localparam int B_CE2    = 5;

	logic [5:0]        pins;
	logic [N-1:0][5:0] samp; // [0] newest, [N-1] oldest

	assign pins = {jce2, jce1, jupdate, jshift, jtdi, jtck};

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			samp <= '0;
		end else begin
			samp <= {samp[N-2:0], pins};
		end
	end

	// oldest still low, next one already high
	assign tck_rise = !samp[N-1][B_TCK] && samp[N-2][B_TCK];

	// levels seen just before the edge, same depth as the tck sample
	assign s_tdi    = samp[N-1][B_TDI];
	assign s_shift  = samp[N-1][B_SHIFT];
	assign s_update = samp[N-1][B_UPDATE];
	assign s_ce1    = samp[N-1][B_CE1];
	assign s_ce2    = samp[N-1][B_CE2];

endmodule

`default_nettype wire
